// ==== files.f ====
rtl/softmax_types_pkg.sv
rtl/softmax_fixed_pkg.sv
rtl/exp2_unit.sv
rtl/element_buffer.sv
rtl/serial_divider.sv
rtl/vector_softmax.sv
rtl/softmax_top.sv
testbench/softmax_tb.sv

// ==== Makefile ====
TOP   := softmax_tb
BUILD := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD) -f files.f
	./$(BUILD)/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf $(BUILD) sim.log

// ==== testbench/softmax_tb.sv ====
// Runs the DUT at MAX_SIZE 16 with repeatable xorshift stimulus and expects READY to close every run
module softmax_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import softmax_fixed_pkg::*;

  localparam int MAX_SIZE    = 16;
  localparam int IDX_W       = $clog2(MAX_SIZE);
  localparam int SIZE_W      = IDX_W + 1;
  localparam int RANDOM_RUNS = 30;

  // Worst run: 4 cycles per input, 32 per output, plus slack
  localparam int RUN_CYCLES     = 16 * 4 + 16 * 32 + 20;
  // 1 + 4 + 30 + 1 + 2 runs
  localparam int NUM_RUNS       = 38;
  localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES;

  // DUT ports
  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic [   SIZE_W-1:0] SIZE_IN;
  logic                 DATA_IN_ENABLE;
  logic [ IN_WIDTH-1:0] DATA_IN;
  logic                 READY;
  logic                 DATA_OUT_ENABLE;
  logic [OUT_WIDTH-1:0] DATA_OUT;

  // Stimulus and scoreboard state
  logic [31:0]         rng_state;
  logic [IN_WIDTH-1:0] vec[MAX_SIZE];
  int                  expected_q[$];
  int                  out_count;
  logic                run_done;
  int                  num_checks;
  int                  num_errors;
  int                  cycle_count;

  softmax_top #(
    .MAX_SIZE(MAX_SIZE)
  ) dut_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .READY          (READY),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // 32-bit xorshift, 13/17/5
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // (16 + frac) << int, top bit dropped
  function automatic longint model_exp(input logic [IN_WIDTH-1:0] value);
    longint mant;
    mant = 16 + longint'(value[3:0]);
    return mant << value[6:4];
  endfunction

  task automatic report_error(input string msg);
    num_errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // Expected outputs of vec[0..n-1], in order
  task automatic push_model(input int n);
    int     i;
    longint sum;
    longint q;
    sum = 0;
    for (i = 0; i < n; i++) begin
      sum += model_exp(vec[i]);
    end
    for (i = 0; i < n; i++) begin
      q = (model_exp(vec[i]) * 65536) / sum;
      // Lone element gives exactly 1.0
      if (q > 65535) begin
        q = 65535;
      end
      expected_q.push_back(32'(q));
    end
  endtask

  task automatic fill_random(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      vec[i] = IN_WIDTH'(next_random());
    end
  endtask

  // START pulse with the length, one cycle wide
  task automatic start_run(input int n);
    @(negedge CLK);
    run_done  = 1'b0;
    out_count = 0;
    START     = 1'b1;
    SIZE_IN   = SIZE_W'(n);
    @(negedge CLK);
    START = 1'b0;
  endtask

  // One strobe per element, optional 0..3 idle cycles before each
  task automatic feed_elements(input int n, input bit use_gaps);
    int i;
    int gap;
    for (i = 0; i < n; i++) begin
      gap = use_gaps ? int'(next_random() % 4) : 0;
      repeat (gap) @(negedge CLK);
      DATA_IN_ENABLE = 1'b1;
      DATA_IN        = vec[i];
      @(negedge CLK);
      DATA_IN_ENABLE = 1'b0;
    end
  endtask

  // Flags are set on negedge, so look at them on posedge
  task automatic wait_outputs(input int k);
    int waited;
    waited = 0;
    while (out_count < k && waited < RUN_CYCLES) begin
      @(posedge CLK);
      waited++;
    end
    if (out_count < k) begin
      num_errors++;
      $display("Run stalled: only %0d of %0d outputs seen at %0t ns", out_count, k, $time);
    end
  endtask

  task automatic wait_run_end(input int n);
    int waited;
    waited = 0;
    while (!run_done && waited < RUN_CYCLES) begin
      @(posedge CLK);
      waited++;
    end
    num_checks++;
    if (!run_done) begin
      num_errors++;
      $display("Run did not finish: no READY within %0d cycles at %0t ns", RUN_CYCLES, $time);
    end else if (out_count != n) begin
      report_error($sformatf("run gave %0d outputs, expected %0d", out_count, n));
    end
  endtask

  task automatic end_test(input string name, input int runs, input int errs_before);
    $display("%s: %0d runs, %0d errors", name, runs, num_errors - errs_before);
  endtask

  //////////////////////////////
  // Clock, monitor, timeout
  //////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Each output against the queue head
  task automatic check_output();
    logic [31:0] want;
    num_checks++;
    out_count++;
    if (expected_q.size() == 0) begin
      report_error($sformatf("unexpected output %0d", DATA_OUT));
    end else begin
      want = 32'(expected_q.pop_front());
      if ({16'h0000, DATA_OUT} !== want) begin
        report_error($sformatf("output %0d is %0d, expected %0d", out_count, DATA_OUT, want));
      end
      if (READY && expected_q.size() != 0) begin
        report_error("READY before the last output");
      end
      if (!READY && expected_q.size() == 0) begin
        report_error("last output without READY");
      end
    end
    if (READY) begin
      run_done = 1'b1;
    end
  endtask

  // Registered outputs are settled mid-cycle
  initial begin
    forever begin
      @(negedge CLK);
      if (!RST && READY && !DATA_OUT_ENABLE) begin
        report_error("READY without DATA_OUT_ENABLE");
      end
      if (!RST && DATA_OUT_ENABLE) begin
        check_output();
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: simulation still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int                  errs;
    int                  n;
    int                  k;
    int                  i;
    int                  eq_sizes[4];
    logic [IN_WIDTH-1:0] elem;

    rng_state      = 32'd3;
    num_checks     = 0;
    num_errors     = 0;
    out_count      = 0;
    run_done       = 1'b0;
    eq_sizes       = '{1, 3, 8, 16};
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN        = '0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Single element saturates to full scale
    errs = num_errors;
    vec[0] = IN_WIDTH'(next_random());
    expected_q.push_back(65535);
    start_run(1);
    feed_elements(1, 1'b0);
    wait_run_end(1);
    end_test("test 1 single element", 1, errs);

    // Equal elements share 65536 evenly
    errs = num_errors;
    for (k = 0; k < 4; k++) begin
      n    = eq_sizes[k];
      elem = IN_WIDTH'(next_random());
      for (i = 0; i < n; i++) begin
        vec[i] = elem;
        expected_q.push_back((n == 1) ? 65535 : 65536 / n);
      end
      start_run(n);
      feed_elements(n, 1'b1);
      wait_run_end(n);
    end
    end_test("test 2 equal elements", 4, errs);

    errs = num_errors;
    for (k = 0; k < RANDOM_RUNS; k++) begin
      n = int'(next_random() % MAX_SIZE) + 1;
      fill_random(n);
      push_model(n);
      start_run(n);
      feed_elements(n, 1'b1);
      wait_run_end(n);
    end
    end_test("test 3 random vectors", RANDOM_RUNS, errs);

    // START and strobes during the divide phase
    errs = num_errors;
    n = 8;
    fill_random(n);
    push_model(n);
    start_run(n);
    feed_elements(n, 1'b0);
    wait_outputs(1);
    @(negedge CLK);
    START   = 1'b1;
    SIZE_IN = SIZE_W'(3);
    @(negedge CLK);
    START = 1'b0;
    repeat (3) begin
      DATA_IN_ENABLE = 1'b1;
      DATA_IN        = IN_WIDTH'(next_random());
      @(negedge CLK);
      DATA_IN_ENABLE = 1'b0;
      @(negedge CLK);
    end
    wait_run_end(n);
    // A stray run would hit an empty queue here
    repeat (2 * (QUOT_WIDTH + 2)) @(negedge CLK);
    end_test("test 4 inputs while dividing", 1, errs);

    // Reset in the middle of the output stream
    errs = num_errors;
    n = 10;
    fill_random(n);
    push_model(n);
    start_run(n);
    feed_elements(n, 1'b1);
    wait_outputs(2);
    @(negedge CLK);
    RST = 1'b1;
    // Outputs already forced low, drop what the aborted run still owed
    @(posedge CLK);
    expected_q.delete();
    repeat (5) @(negedge CLK);
    RST = 1'b0;
    repeat (2 * (QUOT_WIDTH + 2)) begin
      @(negedge CLK);
      num_checks++;
      if (DATA_OUT_ENABLE || READY) begin
        report_error("output after reset without a new START");
      end
    end
    n = int'(next_random() % MAX_SIZE) + 1;
    fill_random(n);
    push_model(n);
    start_run(n);
    feed_elements(n, 1'b1);
    wait_run_end(n);
    end_test("test 5 reset mid-run", 2, errs);

    $display("Summary: %0d checks, %0d errors", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rtl/softmax_top.sv ====
// MAX_SIZE is a power of two from 2 to 16 and sets buffer depth and SIZE_IN width
module softmax_top #(
  parameter  int MAX_SIZE = 16,
  localparam int IDX_W    = $clog2(MAX_SIZE)
) (
  // Global
  input  logic                                   CLK,
  input  logic                                   RST,

  // Control
  input  logic                                   START,
  input  logic [                        IDX_W:0] SIZE_IN,
  output logic                                   READY,

  // Input stream
  input  logic                                   DATA_IN_ENABLE,
  input  logic [ softmax_fixed_pkg::IN_WIDTH-1:0] DATA_IN,

  // Output stream
  output logic                                   DATA_OUT_ENABLE,
  output logic [softmax_fixed_pkg::OUT_WIDTH-1:0] DATA_OUT
);

  //////////////////////////////
  // Softmax subsystem
  //////////////////////////////

  // Depth fixed here and handed down
  vector_softmax #(
    .MAX_SIZE(MAX_SIZE)
  ) softmax (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .READY          (READY),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT)
  );

endmodule

// ==== rtl/vector_softmax.sv ====
// SIZE_IN must be 1 to MAX_SIZE, START only counts in IDLE and outputs cannot be stalled
module vector_softmax #(
  parameter  int MAX_SIZE = 16,
  localparam int IDX_W    = $clog2(MAX_SIZE)
) (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   START,
  input  logic [                        IDX_W:0] SIZE_IN,
  input  logic                                   DATA_IN_ENABLE,
  input  logic [ softmax_fixed_pkg::IN_WIDTH-1:0] DATA_IN,
  output logic                                   READY,
  output logic                                   DATA_OUT_ENABLE,
  output logic [softmax_fixed_pkg::OUT_WIDTH-1:0] DATA_OUT
);

  import softmax_fixed_pkg::*;
  import softmax_types_pkg::*;

  // FSM and counters
  softmax_state_e state;
  logic [IDX_W:0] size_q;
  logic [IDX_W:0] in_count;
  logic [IDX_W:0] wr_count;
  logic [IDX_W-1:0] out_index;
  logic [SUM_WIDTH-1:0] sum_q;
  logic start_accept;
  logic last_in;
  logic last_out;
  logic [OUT_WIDTH-1:0] quot_sat;

  // Exponential unit
  logic exp_in_enable;
  logic [IN_WIDTH-1:0] exp_in;
  logic exp_out_enable;
  logic [EXP_WIDTH-1:0] exp_out;

  // Buffer
  logic wr_enable;
  logic [IDX_W-1:0] wr_index;
  logic [EXP_WIDTH-1:0] wr_data;
  logic [IDX_W-1:0] rd_index;
  logic [EXP_WIDTH-1:0] rd_data;

  // Divider
  logic div_start;
  logic div_done;
  logic [QUOT_WIDTH-1:0] dividend;
  logic [SUM_WIDTH-1:0] divisor;
  logic [QUOT_WIDTH-1:0] quotient;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign start_accept = (state == IDLE) && START;
  assign last_in      = (in_count + 1'b1) == size_q;
  assign last_out     = ({1'b0, out_index} + 1'b1) == size_q;

  // exp/sum is 1.0 for a lone element so clamp
  assign quot_sat = (|quotient[QUOT_WIDTH-1:OUT_WIDTH]) ? '1 : quotient[OUT_WIDTH-1:0];

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= IDLE;
      size_q          <= '0;
      in_count        <= '0;
      out_index       <= '0;
      exp_in_enable   <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // Pulses by default
      exp_in_enable   <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      case (state)
        IDLE: begin
          if (START) begin
            size_q    <= SIZE_IN;
            in_count  <= '0;
            out_index <= '0;
            state     <= LOAD;
          end
        end
        LOAD: begin
          if (DATA_IN_ENABLE) begin
            exp_in_enable <= 1'b1;
            in_count      <= in_count + 1'b1;
            if (last_in) begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          // Sum complete once every slot is written
          if (wr_count == size_q) begin
            state <= DIVIDE;
          end
        end
        DIVIDE: begin
          state <= WAIT_DIV;
        end
        WAIT_DIV: begin
          if (div_done) begin
            DATA_OUT_ENABLE <= 1'b1;
            if (last_out) begin
              READY <= 1'b1;
              state <= IDLE;
            end else begin
              out_index <= out_index + 1'b1;
              state     <= DIVIDE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Element forwarded one cycle after its strobe
  always_ff @(posedge CLK) begin
    if (state == LOAD && DATA_IN_ENABLE) begin
      exp_in <= DATA_IN;
    end
    if (state == WAIT_DIV && div_done) begin
      DATA_OUT <= quot_sat;
    end
  end

  //////////////////////////////
  // Sum and write pointer
  //////////////////////////////

  // Exponentials return in order so a counter gives the slot
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_count <= '0;
      sum_q    <= '0;
    end else if (start_accept) begin
      wr_count <= '0;
      sum_q    <= '0;
    end else if (exp_out_enable) begin
      wr_count <= wr_count + 1'b1;
      sum_q    <= sum_q + SUM_WIDTH'(exp_out);
    end
  end

  assign wr_enable = exp_out_enable;
  assign wr_index  = wr_count[IDX_W-1:0];
  assign wr_data   = exp_out;
  assign rd_index  = out_index;

  // Divider fed straight from the buffer read port
  assign div_start = (state == DIVIDE);
  assign dividend  = {rd_data, {OUT_WIDTH{1'b0}}};
  assign divisor   = sum_q;

  //////////////////////////////
  // Submodules
  //////////////////////////////

  exp2_unit exp2 (
    .CLK       (CLK),
    .RST       (RST),
    .in_enable (exp_in_enable),
    .in_value  (exp_in),
    .out_enable(exp_out_enable),
    .out_value (exp_out)
  );

  element_buffer #(
    .MAX_SIZE(MAX_SIZE)
  ) buffer (
    .CLK      (CLK),
    .wr_enable(wr_enable),
    .wr_index (wr_index),
    .wr_data  (wr_data),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  serial_divider divider (
    .CLK     (CLK),
    .RST     (RST),
    .start   (div_start),
    .dividend(dividend),
    .divisor (divisor),
    .done    (div_done),
    .quotient(quotient)
  );

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Length legal when a run begins
  a_size_legal : assert property (@(posedge CLK) disable iff (RST)
    start_accept |-> (SIZE_IN != '0) && (SIZE_IN <= MAX_SIZE));

  // READY only rides on an output and no slot changed after the drain
  a_ready_last : assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE && (wr_count == size_q));

endmodule

// ==== rtl/serial_divider.sv ====
// Divisor must be nonzero and start is accepted only when idle; done follows start by QUOT_WIDTH cycles
module serial_divider (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    start,
  input  logic [softmax_fixed_pkg::QUOT_WIDTH-1:0] dividend,
  input  logic [ softmax_fixed_pkg::SUM_WIDTH-1:0] divisor,
  output logic                                    done,
  output logic [softmax_fixed_pkg::QUOT_WIDTH-1:0] quotient
);

  import softmax_fixed_pkg::*;
  import softmax_types_pkg::*;

  localparam int CNT_W = $clog2(QUOT_WIDTH);

  div_state_e state;
  logic [     CNT_W-1:0] bit_count;

  // Partial remainder, latched divisor, dividend/quotient shifter
  logic [ SUM_WIDTH-1:0] remainder;
  logic [ SUM_WIDTH-1:0] divisor_q;
  logic [QUOT_WIDTH-1:0] shift_q;

  // One restoring step
  logic [ SUM_WIDTH-1:0] rem_src;
  logic [QUOT_WIDTH-1:0] shift_src;
  logic [ SUM_WIDTH-1:0] div_src;
  logic [   SUM_WIDTH:0] trial;
  logic                  fits;
  logic [ SUM_WIDTH-1:0] rem_next;
  logic [QUOT_WIDTH-1:0] shift_next;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // First bit is settled on the start edge straight from the inputs
  always_comb begin
    if (state == DIV_IDLE) begin
      rem_src   = '0;
      shift_src = dividend;
      div_src   = divisor;
    end else begin
      rem_src   = remainder;
      shift_src = shift_q;
      div_src   = divisor_q;
    end
    // Bring down next dividend bit
    trial      = {rem_src, shift_src[QUOT_WIDTH-1]};
    fits       = trial >= {1'b0, div_src};
    // Restore by keeping the trial when it does not fit
    rem_next   = fits ? SUM_WIDTH'(trial - {1'b0, div_src}) : trial[SUM_WIDTH-1:0];
    shift_next = {shift_src[QUOT_WIDTH-2:0], fits};
  end

  always_ff @(posedge CLK) begin
    if ((state == DIV_IDLE && start) || state == DIV_BUSY) begin
      remainder <= rem_next;
      shift_q   <= shift_next;
      divisor_q <= div_src;
    end
  end

  // Quotient bits have fully replaced the dividend once done
  assign quotient = shift_q;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= DIV_IDLE;
      bit_count <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (start) begin
            // One bit already done
            bit_count <= CNT_W'(1);
            state     <= DIV_BUSY;
          end
        end
        DIV_BUSY: begin
          bit_count <= bit_count + 1'b1;
          // Last bit lands on this edge
          if (bit_count == CNT_W'(QUOT_WIDTH - 1)) begin
            done  <= 1'b1;
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Controller must wait for done before the next start
  a_no_start_busy : assert property (@(posedge CLK) disable iff (RST)
    start |-> state == DIV_IDLE);

  // Sum of exponentials is never zero
  a_divisor_nonzero : assert property (@(posedge CLK) disable iff (RST)
    start |-> divisor != '0);

endmodule

// ==== rtl/element_buffer.sv ====
// MAX_SIZE must be a power of two from 2 to 16 and read data is combinational from rd_index
module element_buffer #(
  parameter  int MAX_SIZE = 16,
  localparam int IDX_W    = $clog2(MAX_SIZE)
) (
  input  logic                                   CLK,
  input  logic                                   wr_enable,
  input  logic [                      IDX_W-1:0] wr_index,
  input  logic [softmax_fixed_pkg::EXP_WIDTH-1:0] wr_data,
  input  logic [                      IDX_W-1:0] rd_index,
  output logic [softmax_fixed_pkg::EXP_WIDTH-1:0] rd_data
);

  import softmax_fixed_pkg::*;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // One exponential per vector slot
  logic [EXP_WIDTH-1:0] mem[MAX_SIZE];

  // Written in arrival order during load
  always_ff @(posedge CLK) begin
    if (wr_enable) begin
      mem[wr_index] <= wr_data;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Async read so the divider sees the value in the same cycle
  assign rd_data = mem[rd_index];

endmodule

// ==== rtl/exp2_unit.sv ====
// Input bit 7 is ignored and the result is a linear 2^x estimate valid one cycle later
module exp2_unit (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   in_enable,
  input  logic [ softmax_fixed_pkg::IN_WIDTH-1:0] in_value,
  output logic                                   out_enable,
  output logic [softmax_fixed_pkg::EXP_WIDTH-1:0] out_value
);

  import softmax_fixed_pkg::*;

  // Integer part sits between the unused MSB and the fraction
  localparam int INT_BITS = IN_WIDTH - 1 - FRAC_BITS;

  logic [ INT_BITS-1:0] int_part;
  logic [FRAC_BITS-1:0] frac_part;
  logic [EXP_WIDTH-1:0] mantissa;

  //////////////////////////////
  // Field split
  //////////////////////////////

  assign int_part  = in_value[IN_WIDTH-2:FRAC_BITS];
  assign frac_part = in_value[FRAC_BITS-1:0];

  // Hidden one plus fraction, i.e. 16 + frac
  assign mantissa  = EXP_WIDTH'({1'b1, frac_part});

  //////////////////////////////
  // Output stage
  //////////////////////////////

  // Strobe follows the data by exactly one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_enable <= 1'b0;
    end else begin
      out_enable <= in_enable;
    end
  end

  // Shift by integer part, no overflow at max input
  always_ff @(posedge CLK) begin
    if (in_enable) begin
      out_value <= mantissa << int_part;
    end
  end

endmodule

// ==== rtl/softmax_fixed_pkg.sv ====
// Widths assume vectors of at most 16 elements so that the running sum never wraps
package softmax_fixed_pkg;

  //////////////////////////////
  // Input format
  //////////////////////////////

  // Q3.4 log2 element, top bit unused
  localparam int IN_WIDTH = 8;

  // Fraction bits of an element
  localparam int FRAC_BITS = 4;

  //////////////////////////////
  // Internal formats
  //////////////////////////////

  // (16 + frac) << 7 peaks at 3968
  localparam int EXP_WIDTH = 12;

  // 16 x 3968 = 63488 still fits
  localparam int SUM_WIDTH = 16;

  //////////////////////////////
  // Output format
  //////////////////////////////

  // Probability scaled by 65536, saturated
  localparam int OUT_WIDTH = 16;

  // Dividend is exp << OUT_WIDTH
  localparam int QUOT_WIDTH = EXP_WIDTH + OUT_WIDTH;

endpackage

// ==== rtl/softmax_types_pkg.sv ====
// State encodings only; divider literals carry a DIV_ prefix so both enums share one scope
package softmax_types_pkg;

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  // Softmax controller phases
  typedef enum logic [2:0] {
    // Waiting for START
    IDLE,
    // Taking elements on DATA_IN_ENABLE
    LOAD,
    // Last exponential still in flight
    DRAIN,
    // Kick one division
    DIVIDE,
    // Division running
    WAIT_DIV
  } softmax_state_e;

  //////////////////////////////
  // Divider FSM
  //////////////////////////////

  // Serial divider activity
  typedef enum logic {
    DIV_IDLE,
    DIV_BUSY
  } div_state_e;

endpackage
